// File: Makefile
VERILATOR ?= verilator
TOP := slc3Tb
FLIST := flist.f
OBJ_DIR := obj_dir
FLAGS := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FLIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
verilog/slc3Pkg.sv
verilog/hexDriver.sv
verilog/isdu.sv
verilog/datapath.sv
verilog/regAlu.sv
verilog/mem2Io.sv
verilog/slc3.sv
sim/slc3Tb.sv

// File: sim/slc3Tb.sv
`timescale 1ns/1ps
`default_nettype none

module slc3Tb;

	localparam int progLen = 40;
	localparam int dataWords = 16;
	localparam logic [15:0] dataBase = 16'h4000;
	localparam int resetCycles = 8;
	localparam int idleCycles = 6;
	localparam int pauseHold = 6;
	localparam int pressCycles = 3;
	// Ten cycles per instruction at most, doubled, plus reset, idle and pause handshakes
	localparam int cycleLimit = progLen * 10 * 2 + 3 * (pauseHold + pressCycles + 2)
		+ resetCycles + idleCycles + 4;

	logic Clk;
	logic rstN;
	logic runIn;
	logic continueIn;
	logic [15:0] switches;
	logic [15:0] sramRdata;
	slc3Pkg::sramReqT sramReq;
	logic [11:0] led;
	logic [7:0][6:0] hex;

	// SRAM contents and the reference copy
	logic [15:0] sram [0:65535];
	logic [15:0] refMem [0:65535];
	logic [15:0] prog [0:progLen-1];

	// Reference machine state
	logic [15:0] refReg [0:7];
	logic [15:0] refPc;
	logic refN;
	logic refZ;
	logic refP;
	logic [15:0] refDisplay;
	int storeCount;

	// Expected events in program order
	logic [19:0] expAddr [$];
	logic [15:0] expData [$];
	logic [11:0] pauseLed [$];
	logic [15:0] pausePc [$];
	logic [15:0] pauseDisp [$];
	int pauseStores [$];

	integer seed;
	int cycles = 0;
	int sramWrites = 0;
	logic weLast;

	initial Clk = 1'b0;
	always #2 Clk = ~Clk;

	slc3 uut (
		.Clk(Clk),
		.rstN(rstN),
		.runIn(runIn),
		.continueIn(continueIn),
		.switches(switches),
		.sramRdata(sramRdata),
		.sramReq(sramReq),
		.led(led),
		.hex(hex)
	);

	// SRAM answers while oe is low
	assign sramRdata = sramReq.oe ? 16'h0000 : sram[sramReq.addr[15:0]];

	always @(posedge Clk) begin
		if (!sramReq.ce && !sramReq.we) begin
			sram[sramReq.addr[15:0]] = sramReq.wdata;
		end
	end

	task automatic failRun();
		$display("SIMULATION FAILED");
		$fatal(1, "testbench stopped at the first error");
	endtask

	task automatic compareValue(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			failRun();
		end
	endtask

	// Active-low segments g..a
	function automatic logic [6:0] segPattern(input logic [3:0] v);
		case (v)
			4'h0: return 7'h40;
			4'h1: return 7'h79;
			4'h2: return 7'h24;
			4'h3: return 7'h30;
			4'h4: return 7'h19;
			4'h5: return 7'h12;
			4'h6: return 7'h02;
			4'h7: return 7'h78;
			4'h8: return 7'h00;
			4'h9: return 7'h10;
			4'hA: return 7'h08;
			4'hB: return 7'h03;
			4'hC: return 7'h46;
			4'hD: return 7'h21;
			4'hE: return 7'h06;
			default: return 7'h0E;
		endcase
	endfunction

	function automatic logic [27:0] segDigits(input logic [15:0] v);
		return {segPattern(v[15:12]), segPattern(v[11:8]), segPattern(v[7:4]),
			segPattern(v[3:0])};
	endfunction

	// Each new store must match the next one the model made
	task automatic matchStore(input logic [19:0] addr, input logic [15:0] data);
		if (expAddr.size() == 0) begin
			$display("Unexpected SRAM write at 0x%h after all model stores were seen", addr);
			failRun();
		end else begin
			compareValue("sramReq.addr", 32'(addr), 32'(expAddr.pop_front()));
			compareValue("sramReq.wdata", 32'(data), 32'(expData.pop_front()));
			sramWrites = sramWrites + 1;
		end
	endtask

	always @(posedge Clk) begin
		if (!rstN) begin
			weLast <= 1'b1;
		end else begin
			// Falling we marks one store
			if (!sramReq.we && weLast) begin
				matchStore(sramReq.addr, sramReq.wdata);
			end
			weLast <= sramReq.we;
		end
	end

	always @(posedge Clk) begin
		cycles = cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout, the program did not reach its last PAUSE in %0d cycles", cycles);
			failRun();
		end
	end

	// Random body word, branches stay at or before limit
	task automatic randomBodyInstr(input int idx, input int limit, output logic [15:0] word);
		logic [31:0] r;
		logic [2:0] kind;
		logic [2:0] dr;
		int maxOff;
		int brOff;
		r = $random(seed);
		kind = r[2:0];
		// R0, R6 and R7 are reserved
		dr = 3'd1 + (r[5:3] % 3'd5);
		maxOff = limit - idx - 1;
		brOff = (maxOff > 0) ? int'(r[31:25]) % (maxOff + 1) : 0;
		case (kind)
			3'd0, 3'd1: word = r[24] ? {4'b0001, dr, r[8:6], 1'b1, r[16:12]}
				: {4'b0001, dr, r[8:6], 3'b000, r[11:9]};
			3'd2, 3'd7: word = r[24] ? {4'b0101, dr, r[8:6], 1'b1, r[16:12]}
				: {4'b0101, dr, r[8:6], 3'b000, r[11:9]};
			3'd3: word = {4'b1001, dr, r[8:6], 6'b111111};
			3'd4: word = {4'b0110, dr, 3'd0, 2'b00, r[20:17]};
			3'd5: word = {4'b0111, r[8:6], 3'd0, 2'b00, r[20:17]};
			default: word = {4'b0000, r[23:21], 9'(brOff)};
		endcase
	endtask

	task automatic buildProgram();
		logic [31:0] r;
		logic [11:0] fields [0:2];
		for (int k = 0; k < 3; k++) begin
			// Distinct nonzero fields so each PAUSE is visible on led
			do begin
				r = $random(seed);
				fields[k] = r[11:0];
			end while (fields[k] == 12'h000 || (k > 0 && fields[k] == fields[0])
				|| (k > 1 && fields[k] == fields[1]));
		end
		// R6 <- 0xFFFF and R0 <- 0x4000 from constants below address 0
		prog[0] = {4'b0110, 3'd6, 3'd0, 6'b111101};
		prog[1] = {4'b0110, 3'd0, 3'd0, 6'b111110};
		// R1 <- switches, then store it
		prog[2] = {4'b0110, 3'd1, 3'd6, 6'd0};
		prog[3] = {4'b0111, 3'd1, 3'd0, 6'd0};
		for (int i = 4; i < 12; i++) randomBodyInstr(i, 12, prog[i]);
		prog[12] = {4'b1101, fields[0]};
		// JSR to the routine at 28
		prog[13] = {4'b0100, 1'b1, 11'd14};
		for (int i = 14; i < 25; i++) randomBodyInstr(i, 25, prog[i]);
		r = $random(seed);
		// Display write through R6
		prog[25] = {4'b0111, 3'd1 + (r[2:0] % 3'd5), 3'd6, 6'd0};
		prog[26] = {4'b1101, fields[1]};
		// Step over the routine, CC is set since the first LDR
		prog[27] = {4'b0000, 3'b111, 9'd8};
		for (int i = 28; i < 35; i++) randomBodyInstr(i, 35, prog[i]);
		prog[35] = {4'b1100, 3'd0, 3'd7, 6'd0};
		for (int i = 36; i < 39; i++) randomBodyInstr(i, 39, prog[i]);
		prog[39] = {4'b1101, fields[2]};
	endtask

	task automatic loadMemories();
		logic [15:0] fill;
		for (int a = 0; a < 65536; a++) begin
			fill = {a[7:0], a[15:8]} ^ 16'h3C5A;
			sram[a] = fill;
			refMem[a] = fill;
		end
		for (int i = 0; i < progLen; i++) begin
			sram[i] = prog[i];
			refMem[i] = prog[i];
		end
		sram[16'hFFFD] = 16'hFFFF;
		refMem[16'hFFFD] = 16'hFFFF;
		sram[16'hFFFE] = dataBase;
		refMem[16'hFFFE] = dataBase;
	endtask

	task automatic setFlags(input logic [15:0] v);
		refN = v[15];
		refZ = (v == 16'h0000);
		refP = !v[15] && (v != 16'h0000);
	endtask

	// Instruction level LC-3 rules
	task automatic executeReference();
		logic [15:0] ir;
		logic [15:0] val;
		logic [15:0] opB;
		logic [15:0] addr;
		int steps;
		bit done;
		for (int i = 0; i < 8; i++) refReg[i] = 16'h0000;
		refPc = 16'h0000;
		setFlags(16'h0000);
		refZ = 1'b0;
		refDisplay = 16'h0000;
		storeCount = 0;
		steps = 0;
		done = 1'b0;
		while (!done && steps < 200) begin
			ir = refMem[refPc];
			refPc = refPc + 16'd1;
			steps++;
			case (ir[15:12])
				4'b0001, 4'b0101, 4'b1001: begin
					opB = ir[5] ? {{11{ir[4]}}, ir[4:0]} : refReg[ir[2:0]];
					if (ir[15:12] == 4'b0001) val = refReg[ir[8:6]] + opB;
					else if (ir[15:12] == 4'b0101) val = refReg[ir[8:6]] & opB;
					else val = ~refReg[ir[8:6]];
					refReg[ir[11:9]] = val;
					setFlags(val);
				end
				4'b0000: begin
					if ((ir[11:9] & {refN, refZ, refP}) != 3'b000) begin
						refPc = refPc + {{7{ir[8]}}, ir[8:0]};
					end
				end
				4'b1100: refPc = refReg[ir[8:6]];
				4'b0100: begin
					refReg[7] = refPc;
					refPc = refPc + {{5{ir[10]}}, ir[10:0]};
				end
				4'b0110: begin
					addr = refReg[ir[8:6]] + {{10{ir[5]}}, ir[5:0]};
					val = (addr == 16'hFFFF) ? switches : refMem[addr];
					refReg[ir[11:9]] = val;
					setFlags(val);
				end
				4'b0111: begin
					addr = refReg[ir[8:6]] + {{10{ir[5]}}, ir[5:0]};
					if (addr == 16'hFFFF) begin
						refDisplay = refReg[ir[11:9]];
					end else begin
						refMem[addr] = refReg[ir[11:9]];
						expAddr.push_back({4'h0, addr});
						expData.push_back(refReg[ir[11:9]]);
						storeCount++;
					end
				end
				4'b1101: begin
					pauseLed.push_back(ir[11:0]);
					pausePc.push_back(refPc);
					pauseDisp.push_back(refDisplay);
					pauseStores.push_back(storeCount);
					if (refPc == 16'(progLen)) done = 1'b1;
				end
				default: ;
			endcase
		end
		if (!done) begin
			$display("Reference model never reached the last PAUSE of the program");
			failRun();
		end
	endtask

	initial begin : mainFlow
		logic [31:0] r;
		rstN = 1'b0;
		runIn = 1'b0;
		continueIn = 1'b0;
		switches = 16'h0000;
		seed = 13;
		r = $random(seed);
		switches = r[15:0];
		buildProgram();
		loadMemories();
		executeReference();

		repeat (resetCycles) @(negedge Clk);
		rstN = 1'b1;

		// Halted after reset until runIn
		repeat (idleCycles) begin
			@(negedge Clk);
			compareValue("sramReq.ce", 32'(sramReq.ce), 32'd0);
			compareValue("sramReq.oe", 32'(sramReq.oe), 32'd1);
			compareValue("sramReq.we", 32'(sramReq.we), 32'd1);
			compareValue("sramReq.ub", 32'(sramReq.ub), 32'd0);
			compareValue("sramReq.lb", 32'(sramReq.lb), 32'd0);
			compareValue("led", 32'(led), 32'd0);
			compareValue("hex[7:4]", 32'(hex[7:4]), 32'(segDigits(16'h0000)));
		end
		runIn = 1'b1;
		@(negedge Clk);
		runIn = 1'b0;

		for (int k = 0; k < 3; k++) begin
			while (led !== pauseLed[k]) @(negedge Clk);
			compareValue("hex[7:4]", 32'(hex[7:4]), 32'(segDigits(pausePc[k])));
			compareValue("hex[3:0]", 32'(hex[3:0]), 32'(segDigits(pauseDisp[k])));
			compareValue("SRAM store count", 32'(sramWrites), 32'(pauseStores[k]));
			// Must hold while continue stays low
			repeat (pauseHold) begin
				@(negedge Clk);
				compareValue("led", 32'(led), 32'(pauseLed[k]));
				compareValue("hex[7:4]", 32'(hex[7:4]), 32'(segDigits(pausePc[k])));
			end
			compareValue("SRAM store count", 32'(sramWrites), 32'(pauseStores[k]));
			if (k < 2) begin
				continueIn = 1'b1;
				repeat (pressCycles) @(negedge Clk);
				compareValue("hex[7:4]", 32'(hex[7:4]), 32'(segDigits(pausePc[k])));
				continueIn = 1'b0;
			end
		end

		// Data region after the last PAUSE
		compareValue("stores left", 32'(expAddr.size()), 32'd0);
		for (int i = 0; i < dataWords; i++) begin
			compareValue("sram data", 32'(sram[dataBase + 16'(i)]),
				32'(refMem[dataBase + 16'(i)]));
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath (
	input  logic               Clk,
	input  logic               rstN,
	input  slc3Pkg::ctrlT      ctrl,
	input  logic [15:0]        aluOut,
	input  logic [15:0]        sr1Out,
	input  logic [15:0]        rdata,
	output logic [15:0]        bus,
	output slc3Pkg::instrU     instr,
	output logic               ben,
	output logic [15:0]        pc,
	output logic [11:0]        led,
	output slc3Pkg::memReqT    memReq
);

	logic [15:0] mar;
	logic [15:0] mdr;
	slc3Pkg::instrU ir;
	logic n;
	logic z;
	logic p;

	logic [15:0] addr1;
	logic [15:0] addr2;
	logic [15:0] adderOut;
	logic [15:0] pcNext;
	logic [8:0] off9;

	assign instr = ir;
	assign off9 = ir.offset.offset9;

	// Address adder
	assign addr1 = ctrl.addr1Mux ? sr1Out : pc;

	always_comb begin
		case (ctrl.addr2Mux)
			slc3Pkg::addr2Off6: addr2 = {{10{off9[5]}}, off9[5:0]};
			slc3Pkg::addr2Off9: addr2 = {{7{off9[8]}}, off9};
			// offset11 borrows the low two nzp bits
			slc3Pkg::addr2Off11: addr2 = {{5{ir.offset.nzp[1]}}, ir.offset.nzp[1:0], off9};
			default: addr2 = 16'h0000;
		endcase
	end

	assign adderOut = addr1 + addr2;

	// Bus gates, at most one is on
	always_comb begin
		if (ctrl.gatePc) begin
			bus = pc;
		end else if (ctrl.gateMdr) begin
			bus = mdr;
		end else if (ctrl.gateAlu) begin
			bus = aluOut;
		end else if (ctrl.gateMarMux) begin
			bus = adderOut;
		end else begin
			bus = 16'h0000;
		end
	end

	always_comb begin
		case (ctrl.pcMux)
			slc3Pkg::pcInc: pcNext = pc + 16'd1;
			slc3Pkg::pcBus: pcNext = bus;
			slc3Pkg::pcAdder: pcNext = adderOut;
			default: pcNext = pc;
		endcase
	end

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			pc <= 16'h0000;
			mar <= 16'h0000;
			mdr <= 16'h0000;
			ir <= '0;
			n <= 1'b0;
			z <= 1'b0;
			p <= 1'b0;
			ben <= 1'b0;
			led <= 12'h000;
		end else begin
			if (ctrl.ldPc) pc <= pcNext;
			if (ctrl.ldMar) mar <= bus;
			// Memory data on reads, bus value for stores
			if (ctrl.ldMdr) mdr <= ctrl.memRead ? rdata : bus;
			if (ctrl.ldIr) ir <= bus;
			if (ctrl.ldCc) begin
				n <= bus[15];
				z <= (bus == 16'h0000);
				p <= !bus[15] && (bus != 16'h0000);
			end
			if (ctrl.ldBen) ben <= |(ir.offset.nzp & {n, z, p});
			if (ctrl.ldLed) led <= ir[11:0];
		end
	end

	assign memReq.addr = mar;
	assign memReq.wdata = mdr;
	assign memReq.read = ctrl.memRead;
	assign memReq.write = ctrl.memWrite;

	// Only one source drives the bus
	assert property (@(posedge Clk) disable iff (!rstN)
		$onehot0({ctrl.gatePc, ctrl.gateMdr, ctrl.gateAlu, ctrl.gateMarMux}));

endmodule

`default_nettype wire

// File: verilog/hexDriver.sv
`timescale 1ns/1ps
`default_nettype none

module hexDriver (
	input  logic [3:0] nibble,
	output logic [6:0] segments
);

	// Segments are g..a, a lit segment is 0
	always_comb begin
		case (nibble)
			4'h0: segments = 7'b1000000;
			4'h1: segments = 7'b1111001;
			4'h2: segments = 7'b0100100;
			4'h3: segments = 7'b0110000;
			4'h4: segments = 7'b0011001;
			4'h5: segments = 7'b0010010;
			4'h6: segments = 7'b0000010;
			4'h7: segments = 7'b1111000;
			4'h8: segments = 7'b0000000;
			4'h9: segments = 7'b0010000;
			4'hA: segments = 7'b0001000;
			4'hB: segments = 7'b0000011;
			4'hC: segments = 7'b1000110;
			4'hD: segments = 7'b0100001;
			4'hE: segments = 7'b0000110;
			default: segments = 7'b0001110;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/isdu.sv
`timescale 1ns/1ps
`default_nettype none

module isdu (
	input  logic               Clk,
	input  logic               rstN,
	input  logic               runIn,
	input  logic               continueIn,
	input  slc3Pkg::instrU     instr,
	input  logic               ben,
	output slc3Pkg::ctrlT      ctrl
);

	slc3Pkg::stateT state;
	slc3Pkg::stateT nextState;
	logic running;
	logic go;

	// Halted in fetch1 until run has been pressed once
	assign go = running | runIn;

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			state <= slc3Pkg::fetch1;
			running <= 1'b0;
		end else begin
			state <= nextState;
			if (runIn) begin
				running <= 1'b1;
			end
		end
	end

	// Next state
	always_comb begin
		nextState = state;
		case (state)
			slc3Pkg::fetch1: if (go) nextState = slc3Pkg::fetch2a;
			slc3Pkg::fetch2a: nextState = slc3Pkg::fetch2b;
			slc3Pkg::fetch2b: nextState = slc3Pkg::fetch3;
			slc3Pkg::fetch3: nextState = slc3Pkg::decode;
			slc3Pkg::decode: begin
				case (instr.operate.opcode)
					slc3Pkg::add, slc3Pkg::andOp, slc3Pkg::notOp: nextState = slc3Pkg::exAlu;
					slc3Pkg::br: nextState = slc3Pkg::exBr;
					slc3Pkg::jmp: nextState = slc3Pkg::exJmp;
					slc3Pkg::jsr: nextState = slc3Pkg::exJsr1;
					slc3Pkg::ldr: nextState = slc3Pkg::exLdr1;
					slc3Pkg::str: nextState = slc3Pkg::exStr1;
					slc3Pkg::pause: nextState = slc3Pkg::pause1;
					// Unsupported opcodes act as no-ops
					default: nextState = slc3Pkg::fetch1;
				endcase
			end
			// BEN was loaded during decode
			slc3Pkg::exBr: nextState = ben ? slc3Pkg::exBrTaken : slc3Pkg::fetch1;
			slc3Pkg::exJsr1: nextState = slc3Pkg::exJsr2;
			slc3Pkg::exLdr1: nextState = slc3Pkg::exLdr2a;
			slc3Pkg::exLdr2a: nextState = slc3Pkg::exLdr2b;
			slc3Pkg::exLdr2b: nextState = slc3Pkg::exLdr3;
			slc3Pkg::exStr1: nextState = slc3Pkg::exStr2;
			slc3Pkg::exStr2: nextState = slc3Pkg::exStr3a;
			slc3Pkg::exStr3a: nextState = slc3Pkg::exStr3b;
			// Press then release continue
			slc3Pkg::pause1: if (continueIn) nextState = slc3Pkg::pause2;
			slc3Pkg::pause2: if (!continueIn) nextState = slc3Pkg::fetch1;
			default: nextState = slc3Pkg::fetch1;
		endcase
	end

	// Control outputs per state
	always_comb begin
		ctrl = '0;
		case (state)
			slc3Pkg::fetch1: begin
				// MAR <- PC, PC <- PC + 1
				if (go) begin
					ctrl.gatePc = 1'b1;
					ctrl.ldMar = 1'b1;
					ctrl.ldPc = 1'b1;
					ctrl.pcMux = slc3Pkg::pcInc;
				end
			end
			slc3Pkg::fetch2a: ctrl.memRead = 1'b1;
			slc3Pkg::fetch2b: begin
				ctrl.memRead = 1'b1;
				ctrl.ldMdr = 1'b1;
			end
			slc3Pkg::fetch3: begin
				ctrl.gateMdr = 1'b1;
				ctrl.ldIr = 1'b1;
			end
			slc3Pkg::decode: ctrl.ldBen = 1'b1;
			slc3Pkg::exAlu: begin
				ctrl.gateAlu = 1'b1;
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
				ctrl.sr1Mux = 1'b1;
				case (instr.operate.opcode)
					slc3Pkg::andOp: ctrl.aluK = slc3Pkg::aluAnd;
					slc3Pkg::notOp: ctrl.aluK = slc3Pkg::aluNot;
					default: ctrl.aluK = slc3Pkg::aluAdd;
				endcase
			end
			slc3Pkg::exBrTaken: begin
				ctrl.ldPc = 1'b1;
				ctrl.pcMux = slc3Pkg::pcAdder;
				ctrl.addr2Mux = slc3Pkg::addr2Off9;
			end
			slc3Pkg::exJmp: begin
				// PC <- BaseR + 0
				ctrl.ldPc = 1'b1;
				ctrl.pcMux = slc3Pkg::pcAdder;
				ctrl.addr1Mux = 1'b1;
				ctrl.sr1Mux = 1'b1;
				ctrl.addr2Mux = slc3Pkg::addr2Zero;
			end
			slc3Pkg::exJsr1: begin
				// R7 <- PC
				ctrl.gatePc = 1'b1;
				ctrl.ldReg = 1'b1;
				ctrl.drMux = 1'b1;
			end
			slc3Pkg::exJsr2: begin
				ctrl.ldPc = 1'b1;
				ctrl.pcMux = slc3Pkg::pcAdder;
				ctrl.addr2Mux = slc3Pkg::addr2Off11;
			end
			slc3Pkg::exLdr1, slc3Pkg::exStr1: begin
				// MAR <- BaseR + offset6
				ctrl.gateMarMux = 1'b1;
				ctrl.ldMar = 1'b1;
				ctrl.addr1Mux = 1'b1;
				ctrl.sr1Mux = 1'b1;
				ctrl.addr2Mux = slc3Pkg::addr2Off6;
			end
			slc3Pkg::exLdr2a: ctrl.memRead = 1'b1;
			slc3Pkg::exLdr2b: begin
				ctrl.memRead = 1'b1;
				ctrl.ldMdr = 1'b1;
			end
			slc3Pkg::exLdr3: begin
				ctrl.gateMdr = 1'b1;
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
			end
			slc3Pkg::exStr2: begin
				// MDR <- SR through the ALU
				ctrl.gateAlu = 1'b1;
				ctrl.aluK = slc3Pkg::aluPass;
				ctrl.ldMdr = 1'b1;
			end
			slc3Pkg::exStr3a, slc3Pkg::exStr3b: ctrl.memWrite = 1'b1;
			slc3Pkg::pause1: ctrl.ldLed = 1'b1;
			default: ctrl = '0;
		endcase
	end

	// A memory access holds for exactly two cycles and never reads and writes at once
	assert property (@(posedge Clk) disable iff (!rstN)
		$rose(ctrl.memRead || ctrl.memWrite) |-> !(ctrl.memRead && ctrl.memWrite)
			##1 $stable({ctrl.memRead, ctrl.memWrite})
			##1 !(ctrl.memRead || ctrl.memWrite));

	// IR takes the word that the two-cycle fetch read just returned
	assert property (@(posedge Clk) disable iff (!rstN)
		ctrl.ldIr |-> $past(ctrl.memRead && ctrl.ldMdr) && $past(ctrl.memRead, 2));

endmodule

`default_nettype wire

// File: verilog/mem2Io.sv
`timescale 1ns/1ps
`default_nettype none

module mem2Io (
	input  logic               Clk,
	input  logic               rstN,
	input  slc3Pkg::memReqT    memReq,
	input  logic [15:0]        switches,
	input  logic [15:0]        sramRdata,
	output logic [15:0]        rdata,
	output slc3Pkg::sramReqT   sramReq,
	output logic [15:0]        hexDigits
);

	logic isIo;

	assign isIo = (memReq.addr == slc3Pkg::ioAddr);

	// Chip always selected, both byte lanes on
	assign sramReq.ce = 1'b0;
	assign sramReq.ub = 1'b0;
	assign sramReq.lb = 1'b0;
	// The I/O location never reaches the SRAM
	assign sramReq.oe = ~(memReq.read & ~isIo);
	assign sramReq.we = ~(memReq.write & ~isIo);
	// 64K address space on a 1M part
	assign sramReq.addr = {4'h0, memReq.addr};
	assign sramReq.wdata = memReq.wdata;

	// Switches answer reads at the I/O location
	assign rdata = isIo ? switches : sramRdata;

	// Display register
	always_ff @(posedge Clk) begin
		if (!rstN) begin
			hexDigits <= 16'h0000;
		end else if (memReq.write && isIo) begin
			hexDigits <= memReq.wdata;
		end
	end

endmodule

`default_nettype wire

// File: verilog/regAlu.sv
`timescale 1ns/1ps
`default_nettype none

module regAlu (
	input  logic               Clk,
	input  logic               rstN,
	input  slc3Pkg::ctrlT      ctrl,
	input  slc3Pkg::instrU     instr,
	input  logic [15:0]        bus,
	output logic [15:0]        aluOut,
	output logic [15:0]        sr1Out
);

	logic [7:0][15:0] regFile;
	logic [2:0] drSel;
	logic [2:0] sr1Sel;
	logic [15:0] sr2Val;
	logic [15:0] bOp;

	// JSR links into R7
	assign drSel = ctrl.drMux ? 3'd7 : instr.operate.dr;
	assign sr1Sel = ctrl.sr1Mux ? instr.operate.sr1 : instr.operate.dr;

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			regFile <= '0;
		end else if (ctrl.ldReg) begin
			regFile[drSel] <= bus;
		end
	end

	assign sr1Out = regFile[sr1Sel];
	assign sr2Val = regFile[instr.operate.src2[2:0]];

	// Immediate form uses sign extended imm5
	assign bOp = instr.operate.immFlag ?
		{{11{instr.operate.src2[4]}}, instr.operate.src2} : sr2Val;

	always_comb begin
		case (ctrl.aluK)
			slc3Pkg::aluAdd: aluOut = sr1Out + bOp;
			slc3Pkg::aluAnd: aluOut = sr1Out & bOp;
			slc3Pkg::aluNot: aluOut = ~sr1Out;
			default: aluOut = sr1Out;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/slc3.sv
`timescale 1ns/1ps
`default_nettype none

module slc3 (
	input  logic               Clk,
	input  logic               rstN,
	input  logic               runIn,
	input  logic               continueIn,
	input  logic [15:0]        switches,
	input  logic [15:0]        sramRdata,
	output slc3Pkg::sramReqT   sramReq,
	output logic [11:0]        led,
	output logic [7:0][6:0]    hex
);

	slc3Pkg::ctrlT ctrl;
	slc3Pkg::instrU instr;
	slc3Pkg::memReqT memReq;
	logic ben;
	logic [15:0] bus;
	logic [15:0] aluOut;
	logic [15:0] sr1Out;
	logic [15:0] rdata;
	logic [15:0] pc;
	logic [15:0] hexDigits;
	logic [7:0][3:0] nibbles;

	isdu uIsdu (
		.Clk(Clk),
		.rstN(rstN),
		.runIn(runIn),
		.continueIn(continueIn),
		.instr(instr),
		.ben(ben),
		.ctrl(ctrl)
	);

	datapath uDatapath (
		.Clk(Clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.aluOut(aluOut),
		.sr1Out(sr1Out),
		.rdata(rdata),
		.bus(bus),
		.instr(instr),
		.ben(ben),
		.pc(pc),
		.led(led),
		.memReq(memReq)
	);

	regAlu uRegAlu (
		.Clk(Clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.instr(instr),
		.bus(bus),
		.aluOut(aluOut),
		.sr1Out(sr1Out)
	);

	mem2Io uMem2Io (
		.Clk(Clk),
		.rstN(rstN),
		.memReq(memReq),
		.switches(switches),
		.sramRdata(sramRdata),
		.rdata(rdata),
		.sramReq(sramReq),
		.hexDigits(hexDigits)
	);

	// Upper four digits show PC, lower four the display register
	assign nibbles = {pc, hexDigits};

	for (genvar i = 0; i < 8; i++) begin : gHex
		hexDriver uHex (
			.nibble(nibbles[i]),
			.segments(hex[i])
		);
	end

endmodule

`default_nettype wire

// File: verilog/slc3Pkg.sv
`default_nettype none

package slc3Pkg;

	// LC-3 opcodes handled by this core
	typedef enum logic [3:0] {
		br    = 4'b0000,
		add   = 4'b0001,
		jsr   = 4'b0100,
		andOp = 4'b0101,
		ldr   = 4'b0110,
		str   = 4'b0111,
		notOp = 4'b1001,
		jmp   = 4'b1100,
		pause = 4'b1101
	} opcodeT;

	// Control states, memory accesses wait through an "a" and a "b" state
	typedef enum logic [4:0] {
		fetch1, fetch2a, fetch2b, fetch3,
		decode,
		exAlu, exBr, exBrTaken, exJmp, exJsr1, exJsr2,
		exLdr1, exLdr2a, exLdr2b, exLdr3,
		exStr1, exStr2, exStr3a, exStr3b,
		pause1, pause2
	} stateT;

	// Operate view
	// src2 carries sr2 in its low three bits, or the full imm5
	typedef struct packed {
		opcodeT     opcode;
		logic [2:0] dr;
		logic [2:0] sr1;
		logic       immFlag;
		logic [4:0] src2;
	} operT;

	// Offset view
	// baseR and offset6 live inside offset9, offset11 reaches into nzp
	typedef struct packed {
		opcodeT     opcode;
		logic [2:0] nzp;
		logic [8:0] offset9;
	} offsetT;

	typedef union packed {
		operT   operate;
		offsetT offset;
	} instrU;

	// PC source select
	localparam logic [1:0] pcInc = 2'd0;
	localparam logic [1:0] pcBus = 2'd1;
	localparam logic [1:0] pcAdder = 2'd2;

	// Second adder operand select
	localparam logic [1:0] addr2Zero = 2'd0;
	localparam logic [1:0] addr2Off6 = 2'd1;
	localparam logic [1:0] addr2Off9 = 2'd2;
	localparam logic [1:0] addr2Off11 = 2'd3;

	// ALU functions
	localparam logic [1:0] aluAdd = 2'd0;
	localparam logic [1:0] aluAnd = 2'd1;
	localparam logic [1:0] aluNot = 2'd2;
	localparam logic [1:0] aluPass = 2'd3;

	typedef struct packed {
		logic       ldMar;
		logic       ldMdr;
		logic       ldIr;
		logic       ldBen;
		logic       ldCc;
		logic       ldReg;
		logic       ldPc;
		logic       ldLed;
		logic       gatePc;
		logic       gateMdr;
		logic       gateAlu;
		logic       gateMarMux;
		logic [1:0] pcMux;
		logic [1:0] addr2Mux;
		// 0 picks PC, 1 picks the sr1 register
		logic       addr1Mux;
		// 1 writes R7 for JSR
		logic       drMux;
		// 0 reads IR[11:9], 1 reads IR[8:6]
		logic       sr1Mux;
		logic [1:0] aluK;
		logic       memRead;
		logic       memWrite;
	} ctrlT;

	// CPU side memory request
	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] wdata;
		logic        read;
		logic        write;
	} memReqT;

	// SRAM pins, strobes are active low
	typedef struct packed {
		logic        ce;
		logic        oe;
		logic        we;
		logic        ub;
		logic        lb;
		logic [19:0] addr;
		logic [15:0] wdata;
	} sramReqT;

	// Switches and display live here
	localparam logic [15:0] ioAddr = 16'hFFFF;

endpackage

`default_nettype wire
